// File: flist.f
+incdir+verification
verilog/decodePkg.sv
verilog/controlDecode.sv
verilog/regFile.sv
verilog/operandFields.sv
verilog/decode.sv
verification/decodeTb.sv

// File: run.sh
#!/bin/sh
# builds and runs the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module decodeTb -f flist.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/VdecodeTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test completed successfully" sim.log; then
   exit 0
fi
exit 1

// File: verification/decodeVectors.svh
/*
   Decode vectors, one entry per instruction case, expected values worked out by hand.
   instr is opcode_rs_rt_rd_funct. ctrl is halt_regWrt_aluOpr_bSrc_{invA invB}_
   {memWrt aluJmp pcOrAdd}_regSrc_{slbi btr branching}_branchCommand_setCtrl.
   Operands are imm1, imm2, toShift, wordAlignJump and then writeRegOut.
   numVectors must match the number of addVec calls.
*/
localparam int numVectors = 38;

task automatic loadVectors();
   // halt, nops and fetch halt
   addVec("halt",   16'b00000_001_010_011_01, 1'b0, 22'b1_0_000_00_00_000_00_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("nop",    16'b00001_001_010_011_01, 1'b0, 22'b0_0_000_00_00_000_00_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("nopFh",  16'b00001_001_010_011_01, 1'b1, 22'b1_0_000_00_00_000_00_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("addiFh", 16'b01000_001_010_011_01, 1'b1, 22'b1_1_100_01_00_000_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   // i-format alu, negative fields show sign and zero extension
   addVec("addi",   16'b01000_100_110_110_10, 1'b0, 22'b0_1_100_01_00_000_10_000_00_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd6);
   addVec("subi",   16'b01001_001_010_011_01, 1'b0, 22'b0_1_100_01_10_000_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("xori",   16'b01010_100_110_110_10, 1'b0, 22'b0_1_111_01_00_000_10_000_00_000,
          16'h001a, 16'h00da, 16'h00da, 16'hfcda, 3'd6);
   addVec("andni",  16'b01011_100_110_110_10, 1'b0, 22'b0_1_101_01_01_000_10_000_00_000,
          16'h001a, 16'h00da, 16'h00da, 16'hfcda, 3'd6);
   // i-format rotates and shifts
   addVec("roli",   16'b10100_001_010_011_01, 1'b0, 22'b0_1_000_01_00_000_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("slli",   16'b10101_001_010_011_01, 1'b0, 22'b0_1_001_01_00_000_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("rori",   16'b10110_100_110_110_10, 1'b0, 22'b0_1_010_01_00_000_10_000_00_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd6);
   addVec("srli",   16'b10111_001_010_011_01, 1'b0, 22'b0_1_011_01_00_000_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   // memory group
   addVec("st",     16'b10000_001_010_011_01, 1'b0, 22'b0_0_100_01_00_100_00_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("ld",     16'b10001_100_110_110_10, 1'b0, 22'b0_1_100_01_00_000_01_000_00_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd6);
   addVec("slbi",   16'b10010_100_110_110_10, 1'b0, 22'b0_1_110_10_00_000_10_100_00_000,
          16'h001a, 16'h00da, 16'h00da, 16'hfcda, 3'd4);
   addVec("stu",    16'b10011_001_010_011_01, 1'b0, 22'b0_1_100_01_00_100_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd1);
   // register group
   addVec("lbi",    16'b11000_100_110_110_10, 1'b0, 22'b0_1_000_10_00_000_11_000_00_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd4);
   addVec("btr",    16'b11001_001_010_011_01, 1'b0, 22'b0_1_000_00_00_000_10_010_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd3);
   addVec("rol",    16'b11010_001_010_011_00, 1'b0, 22'b0_1_000_00_00_000_10_000_00_000,
          16'h000c, 16'h004c, 16'h004c, 16'h014c, 3'd3);
   addVec("sll",    16'b11010_001_010_011_01, 1'b0, 22'b0_1_001_00_00_000_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd3);
   addVec("ror",    16'b11010_001_010_011_10, 1'b0, 22'b0_1_010_00_00_000_10_000_00_000,
          16'h000e, 16'h004e, 16'h004e, 16'h014e, 3'd3);
   addVec("srl",    16'b11010_001_010_011_11, 1'b0, 22'b0_1_011_00_00_000_10_000_00_000,
          16'h000f, 16'h004f, 16'h004f, 16'h014f, 3'd3);
   addVec("add",    16'b11011_001_010_011_00, 1'b0, 22'b0_1_100_00_00_000_10_000_00_000,
          16'h000c, 16'h004c, 16'h004c, 16'h014c, 3'd3);
   addVec("sub",    16'b11011_001_010_011_01, 1'b0, 22'b0_1_100_00_10_000_10_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd3);
   addVec("xor",    16'b11011_001_010_011_10, 1'b0, 22'b0_1_111_00_00_000_10_000_00_000,
          16'h000e, 16'h004e, 16'h004e, 16'h014e, 3'd3);
   addVec("andn",   16'b11011_001_010_011_11, 1'b0, 22'b0_1_101_00_01_000_10_000_00_000,
          16'h000f, 16'h004f, 16'h004f, 16'h014f, 3'd3);
   // compare group
   addVec("seq",    16'b11100_001_010_011_01, 1'b0, 22'b0_1_000_00_00_000_10_000_00_100,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd3);
   addVec("slt",    16'b11101_001_010_011_01, 1'b0, 22'b0_1_000_00_00_000_10_000_00_101,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd3);
   addVec("sle",    16'b11110_001_010_011_01, 1'b0, 22'b0_1_000_00_00_000_10_000_00_110,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd3);
   addVec("sco",    16'b11111_001_010_011_01, 1'b0, 22'b0_1_000_00_00_000_10_000_00_111,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd3);
   // branch group
   addVec("beqz",   16'b01100_100_110_110_10, 1'b0, 22'b0_0_100_00_00_000_00_001_00_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd6);
   addVec("bnez",   16'b01101_001_010_011_01, 1'b0, 22'b0_0_100_00_00_000_00_001_01_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("bltz",   16'b01110_001_010_011_01, 1'b0, 22'b0_0_100_00_01_000_00_001_10_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("bgez",   16'b01111_100_110_110_10, 1'b0, 22'b0_0_100_00_01_000_00_001_11_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd6);
   // jump group
   addVec("j",      16'b00100_100_110_110_10, 1'b0, 22'b0_0_100_00_00_001_00_000_00_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd6);
   addVec("jr",     16'b00101_001_010_011_01, 1'b0, 22'b0_0_100_10_00_010_00_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd2);
   addVec("jal",    16'b00110_001_010_011_01, 1'b0, 22'b0_1_100_00_00_001_00_000_00_000,
          16'h000d, 16'h004d, 16'h004d, 16'h014d, 3'd7);
   addVec("jalr",   16'b00111_100_110_110_10, 1'b0, 22'b0_1_100_10_00_010_00_000_00_000,
          16'hfffa, 16'hffda, 16'h00da, 16'hfcda, 3'd7);
endtask

// File: verification/decodeTb.sv
/*
   Testbench for the decode stage. Controls and operands are compared with a table,
   then the register file with a local 8-entry model.
   Inputs change 5 ns after the rising edge and are sampled 10 ns before the next one.
   Reset is held for 8 cycles with writeback active, and a watchdog bounds the run.
*/
`timescale 1ns/1ps

module decodeTb import decodePkg::*; ();

   localparam int clkPeriod = 100;
   localparam int numWrites = 24;          // random writeback cycles
   localparam int ctrlW     = 22;          // all controls packed in table order

   typedef struct packed {
      logic [dataW-1:0]   instr;
      logic               fetchHalt;
      logic [ctrlW-1:0]   ctrl;
      logic [dataW-1:0]   imm1;
      logic [dataW-1:0]   imm2;
      logic [dataW-1:0]   toShift;
      logic [dataW-1:0]   jump;
      logic [regSelW-1:0] writeReg;
   } vector_t;

   `include "decodeVectors.svh"

   logic clk;
   logic rstN;
   instrWord_t instruction;
   logic fetchHalt;
   logic [regSelW-1:0] writeRegWb;
   logic [dataW-1:0] writeDataWb;
   logic regWrtWb;
   logic [dataW-1:0] readData1, readData2, imm1, imm2, toShift, wordAlignJump;
   logic [regSelW-1:0] writeRegOut;
   logic halt, regWrt, invA, invB, memWrt, aluJmp, pcOrAdd, slbi, btr, branching;
   logic [aluOpW-1:0] aluOpr;
   logic [selW-1:0] bSrc, regSrc, branchCommand;
   logic [setW-1:0] setCtrl;
   logic [ctrlW-1:0] ctrlActual;

   string            vecName [numVectors];
   vector_t          vecs    [numVectors];
   int               vecCount = 0;
   logic [dataW-1:0] model   [numRegs];      // expected register contents
   int               seed = 32'h7b98151b;
   int               ctrlErrors = 0;
   int               operandErrors = 0;
   int               regErrors = 0;
   int               tableErrors = 0;

   assign ctrlActual = {halt, regWrt, aluOpr, bSrc, invA, invB, memWrt, aluJmp, pcOrAdd,
                        regSrc, slbi, btr, branching, branchCommand, setCtrl};

   decode decode_i (
      .clk(clk), .rstN(rstN), .instruction(instruction), .fetchHalt(fetchHalt),
      .writeRegWb(writeRegWb), .writeDataWb(writeDataWb), .regWrtWb(regWrtWb),
      .readData1(readData1), .readData2(readData2), .imm1(imm1), .imm2(imm2),
      .toShift(toShift), .wordAlignJump(wordAlignJump), .writeRegOut(writeRegOut),
      .halt(halt), .regWrt(regWrt), .aluOpr(aluOpr), .bSrc(bSrc), .invA(invA),
      .invB(invB), .memWrt(memWrt), .aluJmp(aluJmp), .pcOrAdd(pcOrAdd), .regSrc(regSrc),
      .slbi(slbi), .btr(btr), .branching(branching), .branchCommand(branchCommand),
      .setCtrl(setCtrl)
   );

   initial clk = 1'b0;
   always #(clkPeriod / 2) clk = ~clk;

   task automatic addVec(input string name, input logic [dataW-1:0] instr, input logic fh,
                         input logic [ctrlW-1:0] ctrl, input logic [dataW-1:0] i1, i2, ts, wj,
                         input logic [regSelW-1:0] wr);
      vecName[vecCount] = name;
      vecs[vecCount]    = '{instr, fh, ctrl, i1, i2, ts, wj, wr};
      vecCount++;
   endtask

   task automatic applyVector(input int i);
      @(posedge clk);
      #5;
      instruction = vecs[i].instr;
      fetchHalt   = vecs[i].fetchHalt;
      #85;                                  // 10 ns before the next edge
      if (ctrlActual !== vecs[i].ctrl) begin
         $display("Mismatch %s controls: expected %b actual %b",
                  vecName[i], vecs[i].ctrl, ctrlActual);
         ctrlErrors++;
      end
      if ({imm1, imm2, toShift, wordAlignJump, writeRegOut} !==
          {vecs[i].imm1, vecs[i].imm2, vecs[i].toShift, vecs[i].jump, vecs[i].writeReg}) begin
         $display("Mismatch %s operands: expected %h %h %h %h %0d actual %h %h %h %h %0d",
                  vecName[i], vecs[i].imm1, vecs[i].imm2, vecs[i].toShift, vecs[i].jump,
                  vecs[i].writeReg, imm1, imm2, toShift, wordAlignJump, writeRegOut);
         operandErrors++;
      end
   endtask

   // reads every register on both ports, rt walks the other way
   task automatic checkAllRegs(input string name);
      int rt;
      for (int r = 0; r < numRegs; r++) begin
         rt = numRegs - 1 - r;
         @(posedge clk);
         #5;
         instruction = {opSys, 2'd1, 3'(r), 3'(rt), 5'd0};   // nop
         fetchHalt   = 1'b0;
         regWrtWb    = 1'b0;
         #85;
         if (readData1 !== model[r]) begin
            $display("Mismatch %s r%0d port 1: expected %h actual %h",
                     name, r, model[r], readData1);
            regErrors++;
         end
         if (readData2 !== model[rt]) begin
            $display("Mismatch %s r%0d port 2: expected %h actual %h",
                     name, rt, model[rt], readData2);
            regErrors++;
         end
      end
   endtask

   // port 2 sees the register being written (old value), port 1 the one written last cycle
   task automatic writeAndRead();
      int prev;
      int r;
      logic [dataW-1:0] data;
      logic en;
      prev = 0;
      for (int k = 0; k < numWrites; k++) begin
         r    = (k < numRegs) ? k : ($random(seed) & 7);   // first pass covers every register
         data = 16'($random(seed));
         en   = (k < numRegs) || (k % 4 != 3);             // some writes disabled
         @(posedge clk);
         #5;
         instruction = {opSys, 2'd1, 3'(prev), 3'(r), 5'd0};
         writeRegWb  = 3'(r);
         writeDataWb = data;
         regWrtWb    = en;
         #85;
         if (readData1 !== model[prev]) begin
            $display("Mismatch write%0d readback r%0d: expected %h actual %h",
                     k, prev, model[prev], readData1);
            regErrors++;
         end
         if (readData2 !== model[r]) begin
            $display("Mismatch write%0d same cycle r%0d: expected %h actual %h",
                     k, r, model[r], readData2);
            regErrors++;
         end
         if (en) model[r] = data;
         prev = r;
      end
   endtask

   initial begin
      rstN        = 1'b0;
      instruction = '0;
      fetchHalt   = 1'b0;
      writeRegWb  = '0;
      writeDataWb = 16'hffff;              // writes during reset must not land
      regWrtWb    = 1'b1;
      for (int r = 0; r < numRegs; r++) model[r] = '0;
      loadVectors();
      if (vecCount != numVectors) begin
         $display("vector table holds %0d entries but %0d are expected", vecCount, numVectors);
         tableErrors++;
      end
      repeat (8) begin
         @(posedge clk);
         #5;
         writeRegWb = writeRegWb + 3'd1;   // one register per reset cycle
      end
      rstN     = 1'b1;
      regWrtWb = 1'b0;
      checkAllRegs("reset");
      for (int i = 0; i < numVectors; i++) applyVector(i);
      writeAndRead();
      checkAllRegs("final");
      $display("errors: control %0d operand %0d register %0d table %0d",
               ctrlErrors, operandErrors, regErrors, tableErrors);
      if (ctrlErrors + operandErrors + regErrors + tableErrors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      #((numVectors + numWrites + 40) * clkPeriod);
      $display("timeout: run did not end within %0d cycles", numVectors + numWrites + 40);
      $display("Test failed");
      $finish;
   end

endmodule

// File: verilog/controlDecode.sv
/*
   Purely combinational instruction decoder. Nothing is registered.
   Every control is inactive for a nop unless fetchHalt is high.
   halt follows fetchHalt for any instruction.
*/
`timescale 1ns/1ps

module controlDecode import decodePkg::*; (
   input  instrWord_t        instruction,
   input  logic              fetchHalt,
   output logic              oExt,           // zero extend the immediates
   output logic [selW-1:0]   regDst,
   output logic              regWrt,
   output logic              halt,
   output logic              btr,
   output logic [aluOpW-1:0] aluOpr,
   output logic [selW-1:0]   bSrc,
   output logic              invA,
   output logic              invB,
   output logic              memWrt,
   output logic              aluJmp,         // next pc from alu result
   output logic              pcOrAdd,        // next pc from pc + displacement
   output logic [selW-1:0]   regSrc,
   output logic              slbi,
   output logic              branching,
   output logic [selW-1:0]   branchCommand,
   output logic [setW-1:0]   setCtrl
);

   logic [groupW-1:0]     group;
   logic [opW-groupW-1:0] subOp;
   logic [functW-1:0]     funct;

   assign group = instruction.rForm.opcode[opW-1:opW-groupW];
   assign subOp = instruction.rForm.opcode[opW-groupW-1:0];
   assign funct = instruction.rForm.funct;

   always_comb begin
      oExt          = 1'b0;
      regDst        = dstRt;
      regWrt        = 1'b0;
      halt          = fetchHalt;      // fetch may already have stopped
      btr           = 1'b0;
      aluOpr        = aluRol;
      bSrc          = bRt;
      invA          = 1'b0;
      invB          = 1'b0;
      memWrt        = 1'b0;
      aluJmp        = 1'b0;
      pcOrAdd       = 1'b0;
      regSrc        = srcPc;
      slbi          = 1'b0;
      branching     = 1'b0;
      branchCommand = brEqz;
      setCtrl       = setNone;

      case (group)
         opSys: begin
            if (subOp == 2'd0) halt = 1'b1;   // other sub-ops are nops
         end
         opAluI: begin
            regWrt = 1'b1;
            bSrc   = bImm5;
            regSrc = srcAlu;
            case (subOp)
               2'd0: aluOpr = aluAdd;                   // addi
               2'd1: begin                              // subi, imm - rs
                  aluOpr = aluAdd;
                  invA   = 1'b1;
               end
               2'd2: begin                              // xori
                  aluOpr = aluXor;
                  oExt   = 1'b1;
               end
               default: begin                           // andni
                  aluOpr = aluAnd;
                  oExt   = 1'b1;
                  invB   = 1'b1;
               end
            endcase
         end
         opShiftI: begin
            regWrt = 1'b1;
            bSrc   = bImm5;                             // alu uses the low 4 bits
            regSrc = srcAlu;
            case (subOp)
               2'd0:    aluOpr = aluRol;
               2'd1:    aluOpr = aluSll;
               2'd2:    aluOpr = aluRor;
               default: aluOpr = aluSrl;
            endcase
         end
         opMem: begin
            aluOpr = aluAdd;                            // address is rs + imm
            bSrc   = bImm5;
            case (subOp)
               2'd0: memWrt = 1'b1;                     // store data comes from rt
               2'd1: begin                              // load
                  regWrt = 1'b1;
                  regSrc = srcMem;
               end
               2'd2: begin                              // slbi, (rs << 8) | imm8
                  slbi   = 1'b1;
                  aluOpr = aluOr;
                  bSrc   = bImm8;
                  oExt   = 1'b1;
                  regDst = dstRs;
                  regSrc = srcAlu;
                  regWrt = 1'b1;
               end
               default: begin                           // store-update writes address to rs
                  memWrt = 1'b1;
                  regWrt = 1'b1;
                  regDst = dstRs;
                  regSrc = srcAlu;
               end
            endcase
         end
         opReg: begin
            regWrt = 1'b1;
            case (subOp)
               2'd0: begin                              // lbi, sign extended imm8
                  regDst = dstRs;
                  bSrc   = bImm8;
                  regSrc = srcImm;
               end
               2'd1: begin                              // bit reverse of rs
                  btr    = 1'b1;
                  regDst = dstRd;
                  regSrc = srcAlu;
               end
               2'd2: begin                              // shift amount from rt
                  regDst = dstRd;
                  regSrc = srcAlu;
                  case (funct)
                     2'd0:    aluOpr = aluRol;
                     2'd1:    aluOpr = aluSll;
                     2'd2:    aluOpr = aluRor;
                     default: aluOpr = aluSrl;
                  endcase
               end
               default: begin
                  regDst = dstRd;
                  regSrc = srcAlu;
                  case (funct)
                     2'd0: aluOpr = aluAdd;
                     2'd1: begin                        // sub is rt - rs
                        aluOpr = aluAdd;
                        invA   = 1'b1;
                     end
                     2'd2: aluOpr = aluXor;
                     default: begin                     // andn
                        aluOpr = aluAnd;
                        invB   = 1'b1;
                     end
                  endcase
               end
            endcase
         end
         opSet: begin
            regWrt = 1'b1;
            regSrc = srcAlu;
            regDst = dstRd;
            case (subOp)
               2'd0:    setCtrl = setEq;
               2'd1:    setCtrl = setLt;
               2'd2:    setCtrl = setLe;
               default: setCtrl = setCarry;
            endcase
         end
         opBranch: begin
            branching     = 1'b1;
            aluOpr        = aluAdd;
            branchCommand = subOp;
            if (subOp == brLtz || subOp == brGez) invB = 1'b1;   // sign tests
         end
         default: begin                                 // jump group
            aluOpr = aluAdd;
            case (subOp)
               2'd0: pcOrAdd = 1'b1;                    // j
               2'd1: begin                              // jr, rs + imm8
                  aluJmp = 1'b1;
                  bSrc   = bImm8;
               end
               2'd2: begin                              // jal
                  pcOrAdd = 1'b1;
                  regWrt  = 1'b1;
                  regDst  = dstLink;
               end
               default: begin                           // jalr
                  aluJmp = 1'b1;
                  bSrc   = bImm8;
                  regWrt = 1'b1;
                  regDst = dstLink;
               end
            endcase
         end
      endcase
   end

endmodule

// File: verilog/decode.sv
/*
   Decode stage of the 16-bit teaching processor.
   Controls and operands are combinational from instruction and fetchHalt.
   The register file is written only through the writeback port, and rs/rt are read.
   There is no stall input.
*/
`timescale 1ns/1ps

module decode import decodePkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  instrWord_t         instruction,
   input  logic               fetchHalt,
   input  logic [regSelW-1:0] writeRegWb,     // destination from writeback
   input  logic [dataW-1:0]   writeDataWb,
   input  logic               regWrtWb,
   output logic [dataW-1:0]   readData1,
   output logic [dataW-1:0]   readData2,
   output logic [dataW-1:0]   imm1,
   output logic [dataW-1:0]   imm2,
   output logic [dataW-1:0]   toShift,
   output logic [dataW-1:0]   wordAlignJump,
   output logic [regSelW-1:0] writeRegOut,
   output logic               halt,
   output logic               regWrt,
   output logic [aluOpW-1:0]  aluOpr,
   output logic [selW-1:0]    bSrc,
   output logic               invA,
   output logic               invB,
   output logic               memWrt,
   output logic               aluJmp,
   output logic               pcOrAdd,
   output logic [selW-1:0]    regSrc,
   output logic               slbi,
   output logic               btr,
   output logic               branching,
   output logic [selW-1:0]    branchCommand,
   output logic [setW-1:0]    setCtrl
);

   logic            oExt;     // decoder to operand extension
   logic [selW-1:0] regDst;

   controlDecode controlDecode_i (
      .instruction  (instruction),
      .fetchHalt    (fetchHalt),
      .oExt         (oExt),
      .regDst       (regDst),
      .regWrt       (regWrt),
      .halt         (halt),
      .btr          (btr),
      .aluOpr       (aluOpr),
      .bSrc         (bSrc),
      .invA         (invA),
      .invB         (invB),
      .memWrt       (memWrt),
      .aluJmp       (aluJmp),
      .pcOrAdd      (pcOrAdd),
      .regSrc       (regSrc),
      .slbi         (slbi),
      .branching    (branching),
      .branchCommand(branchCommand),
      .setCtrl      (setCtrl)
   );

   operandFields operandFields_i (
      .instruction  (instruction),
      .oExt         (oExt),
      .regDst       (regDst),
      .imm1         (imm1),
      .imm2         (imm2),
      .toShift      (toShift),
      .wordAlignJump(wordAlignJump),
      .writeRegOut  (writeRegOut)
   );

   regFile regFile_i (
      .clk      (clk),
      .rstN     (rstN),
      .read1Sel (instruction.rForm.rs),   // port 1 reads rs
      .read2Sel (instruction.rForm.rt),   // port 2 reads rt
      .writeSel (writeRegWb),
      .writeData(writeDataWb),
      .writeEn  (regWrtWb),
      .read1Data(readData1),
      .read2Data(readData2)
   );

endmodule

// File: verilog/decodePkg.sv
/*
   Shared widths, opcode groups and control encodings for the decode stage.
   Bits 15..11 hold the opcode. Bits 15..13 select the group and bits 12..11 the sub-op.
   The control code values must match the execute and writeback stages that use them.
*/
package decodePkg;

   localparam int dataW   = 16;                     // datapath and register width
   localparam int regSelW = 3;
   localparam int numRegs = 8;
   localparam logic [regSelW-1:0] linkReg = 3'd7;   // jal/jalr return address goes here

   localparam int opW    = 5;                       // group plus sub-op
   localparam int groupW = 3;
   localparam int imm5W  = 5;
   localparam int imm8W  = 8;
   localparam int dispW  = 11;                      // jump displacement
   localparam int functW = 2;
   localparam int aluOpW = 3;
   localparam int selW   = 2;                       // width of bSrc, regSrc, regDst, branch codes
   localparam int setW   = 3;

   // opcode groups, instruction[15:13]
   localparam logic [groupW-1:0] opSys    = 3'd0;   // halt and nop
   localparam logic [groupW-1:0] opJump   = 3'd1;
   localparam logic [groupW-1:0] opAluI   = 3'd2;
   localparam logic [groupW-1:0] opBranch = 3'd3;
   localparam logic [groupW-1:0] opMem    = 3'd4;
   localparam logic [groupW-1:0] opShiftI = 3'd5;
   localparam logic [groupW-1:0] opReg    = 3'd6;
   localparam logic [groupW-1:0] opSet    = 3'd7;

   // alu operations
   localparam logic [aluOpW-1:0] aluRol = 3'd0;
   localparam logic [aluOpW-1:0] aluSll = 3'd1;
   localparam logic [aluOpW-1:0] aluRor = 3'd2;
   localparam logic [aluOpW-1:0] aluSrl = 3'd3;
   localparam logic [aluOpW-1:0] aluAdd = 3'd4;
   localparam logic [aluOpW-1:0] aluAnd = 3'd5;
   localparam logic [aluOpW-1:0] aluOr  = 3'd6;
   localparam logic [aluOpW-1:0] aluXor = 3'd7;

   // writeback source
   localparam logic [selW-1:0] srcPc  = 2'd0;       // pc + 2 for the link jumps
   localparam logic [selW-1:0] srcMem = 2'd1;
   localparam logic [selW-1:0] srcAlu = 2'd2;
   localparam logic [selW-1:0] srcImm = 2'd3;

   // alu b operand source
   localparam logic [selW-1:0] bRt   = 2'd0;
   localparam logic [selW-1:0] bImm5 = 2'd1;
   localparam logic [selW-1:0] bImm8 = 2'd2;

   // destination register select
   localparam logic [selW-1:0] dstRt   = 2'd0;      // bits 7..5
   localparam logic [selW-1:0] dstRs   = 2'd1;      // bits 10..8
   localparam logic [selW-1:0] dstRd   = 2'd2;      // bits 4..2
   localparam logic [selW-1:0] dstLink = 2'd3;

   // compare result select
   localparam logic [setW-1:0] setNone  = 3'd0;
   localparam logic [setW-1:0] setEq    = 3'd4;
   localparam logic [setW-1:0] setLt    = 3'd5;
   localparam logic [setW-1:0] setLe    = 3'd6;
   localparam logic [setW-1:0] setCarry = 3'd7;

   // branch conditions, equal to the branch sub-op
   localparam logic [selW-1:0] brEqz = 2'd0;
   localparam logic [selW-1:0] brNez = 2'd1;
   localparam logic [selW-1:0] brLtz = 2'd2;
   localparam logic [selW-1:0] brGez = 2'd3;

   typedef struct packed {
      logic [opW-1:0]     opcode;
      logic [regSelW-1:0] rs;
      logic [regSelW-1:0] rt;
      logic [regSelW-1:0] rd;
      logic [functW-1:0]  funct;
   } rForm_t;

   typedef struct packed {
      logic [opW-1:0]     opcode;
      logic [regSelW-1:0] rs;
      logic [regSelW-1:0] rd;                       // sits where rForm has rt
      logic [imm5W-1:0]   imm5;
   } i1Form_t;

   typedef struct packed {
      logic [opW-1:0]     opcode;
      logic [regSelW-1:0] rs;
      logic [imm8W-1:0]   imm8;
   } i2Form_t;

   typedef struct packed {
      logic [opW-1:0]   opcode;
      logic [dispW-1:0] disp;
   } jForm_t;

   // one 16-bit word with four overlapping format views
   typedef union packed {
      rForm_t  rForm;
      i1Form_t i1Form;
      i2Form_t i2Form;
      jForm_t  jForm;
   } instrWord_t;

endpackage

// File: verilog/operandFields.sv
/*
   Immediate extension, shift operand, jump displacement and destination select.
   Purely combinational. oExt and regDst come from the control decoder.
*/
`timescale 1ns/1ps

module operandFields import decodePkg::*; (
   input  instrWord_t         instruction,
   input  logic               oExt,
   input  logic [selW-1:0]    regDst,
   output logic [dataW-1:0]   imm1,
   output logic [dataW-1:0]   imm2,
   output logic [dataW-1:0]   toShift,
   output logic [dataW-1:0]   wordAlignJump,
   output logic [regSelW-1:0] writeRegOut
);

   logic [imm5W-1:0] imm5;
   logic [imm8W-1:0] imm8;
   logic [dispW-1:0] disp;

   assign imm5 = instruction.i1Form.imm5;
   assign imm8 = instruction.i2Form.imm8;
   assign disp = instruction.jForm.disp;

   // zero extend for logic ops and slbi, sign extend otherwise
   assign imm1 = oExt ? {{(dataW-imm5W){1'b0}}, imm5}
                      : {{(dataW-imm5W){imm5[imm5W-1]}}, imm5};
   assign imm2 = oExt ? {{(dataW-imm8W){1'b0}}, imm8}
                      : {{(dataW-imm8W){imm8[imm8W-1]}}, imm8};

   assign toShift       = {{(dataW-imm8W){1'b0}}, imm8};          // slbi shift operand
   assign wordAlignJump = {{(dataW-dispW){disp[dispW-1]}}, disp};  // j and jal offset

   always_comb begin
      case (regDst)
         dstRt:   writeRegOut = instruction.i1Form.rd;   // i-format destination
         dstRs:   writeRegOut = instruction.i2Form.rs;
         dstRd:   writeRegOut = instruction.rForm.rd;
         default: writeRegOut = linkReg;
      endcase
   end

endmodule

// File: verilog/regFile.sv
/*
   Eight 16-bit registers with two combinational read ports and one write port.
   Writes land on the rising clk edge. There is no write-to-read bypass,
   so a read in the same cycle sees the old value.
*/
`timescale 1ns/1ps

module regFile import decodePkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  logic [regSelW-1:0] read1Sel,
   input  logic [regSelW-1:0] read2Sel,
   input  logic [regSelW-1:0] writeSel,
   input  logic [dataW-1:0]   writeData,
   input  logic               writeEn,
   output logic [dataW-1:0]   read1Data,
   output logic [dataW-1:0]   read2Data
);

   logic [dataW-1:0] regs [numRegs];

   // architectural state starts at zero
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;   // owned by writeback
      end
   end

   assign read1Data = regs[read1Sel];   // rs port
   assign read2Data = regs[read2Sel];   // rt port

endmodule
